//--- list.f
src/owr_pkg.sv
src/beat_fifo.sv
src/stream_writer.sv
src/meta_arbiter.sv
src/cq_router.sv
src/output_writer.sv
verif/output_writer_chk.sv
verif/tb_output_writer.sv

//--- verif/tb_output_writer.sv
`default_nettype none

module tb_output_writer
  import owr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic         clk;
  logic         rst;
  stream_beat_t data_in [N_STRM];
  logic         data_in_valid [N_STRM];
  logic         data_in_ready [N_STRM];
  mem_config_t  mem_config [N_STRM];
  stream_beat_t data_out [N_STRM];
  logic         data_out_valid [N_STRM];
  logic         data_out_ready [N_STRM];
  meta_word_u   sq_wr;
  logic         sq_wr_valid;
  logic         sq_wr_ready;
  cq_t          cq_wr;
  logic         cq_wr_valid;
  logic         cq_wr_ready;
  meta_word_u   notify;
  logic         notify_valid;
  logic         notify_ready;

  // stimulus still to drive, and what the host expects back
  stream_beat_t drive_q [N_STRM][$];
  stream_beat_t exp_beats [N_STRM][$];
  wr_req_t      exp_req [N_STRM][$];
  notify_t      exp_ntf [N_STRM][$];
  // beat counts of requests seen on sq_wr awaiting completion
  int           pend [N_STRM][$];
  int           beats_seen [N_STRM];
  int           beats_done [N_STRM];
  // per-stream completion delay (negative when none is due)
  int           cq_wait [N_STRM];
  logic         in_fired [N_STRM];
  logic         cq_fired;
  logic         bp_on;
  logic         aborted;
  int           errors;
  int           checks;

  output_writer DUT (.*);

  always #5 clk = ~clk;

  task automatic check_req(input wr_req_t exp, input wr_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t sq_wr: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_notify(input notify_t exp, input notify_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t notify: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_beat(input int s, input stream_beat_t exp, input stream_beat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t data_out[%0d]: expected %h, got %h", $time, s, exp, act);
    end
  endtask

  // monitor samples handshakes at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      for (int s = 0; s < N_STRM; s++) begin
        in_fired[s] = data_in_valid[s] && data_in_ready[s];
        if (data_out_valid[s] && data_out_ready[s]) begin
          beats_seen[s]++;
          if (exp_beats[s].size() == 0) begin
            errors++;
            $display("ERROR %0t: beat on data_out[%0d] with none expected", $time, s);
          end else begin
            check_beat(s, exp_beats[s][0], data_out[s]);
            exp_beats[s].delete(0);
          end
        end
      end
      cq_fired = cq_wr_valid && cq_wr_ready;
      if (sq_wr_valid && sq_wr_ready) begin
        if (exp_req[sq_wr.req.stream_id].size() == 0) begin
          errors++;
          $display("ERROR %0t: request on sq_wr with none expected", $time);
        end else begin
          check_req(exp_req[sq_wr.req.stream_id][0], sq_wr.req);
          exp_req[sq_wr.req.stream_id].delete(0);
        end
        pend[sq_wr.req.stream_id].push_back(int'(sq_wr.req.beats));
      end
      if (notify_valid && notify_ready) begin
        if (exp_ntf[notify.ntf.stream_id].size() == 0) begin
          errors++;
          $display("ERROR %0t: notify with none expected", $time);
        end else begin
          check_notify(exp_ntf[notify.ntf.stream_id][0], notify.ntf);
          exp_ntf[notify.ntf.stream_id].delete(0);
        end
      end
    end
  end

  // host and kernel side driven on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      // ready gaps only under back-pressure
      sq_wr_ready = bp_on ? ($urandom() % 4 != 0) : 1'b1;
      notify_ready = bp_on ? ($urandom() % 3 != 0) : 1'b1;
      for (int s = 0; s < N_STRM; s++) begin
        data_out_ready[s] = bp_on ? ($urandom() % 3 != 0) : 1'b1;
        // kernel feeder holds the head until taken
        if (in_fired[s]) begin
          drive_q[s].delete(0);
        end
        if (drive_q[s].size() != 0) begin
          data_in[s] = drive_q[s][0];
          data_in_valid[s] = 1'b1;
        end else begin
          data_in_valid[s] = 1'b0;
        end
      end
      if (cq_fired) begin
        cq_wr_valid = 1'b0;
      end
      // completion once a request and all its beats are in
      for (int s = 0; s < N_STRM; s++) begin
        if (cq_wait[s] < 0 && pend[s].size() != 0 &&
            beats_seen[s] - beats_done[s] >= pend[s][0]) begin
          beats_done[s] += pend[s][0];
          pend[s].delete(0);
          cq_wait[s] = bp_on ? int'($urandom() % 8) : 0;
        end else if (cq_wait[s] > 0) begin
          cq_wait[s]--;
        end
      end
      for (int s = 0; s < N_STRM; s++) begin
        if (cq_wait[s] == 0 && !cq_wr_valid) begin
          cq_wr.stream_id = STRM_ID_W'(s);
          cq_wr.spare = '0;
          cq_wr_valid = 1'b1;
          cq_wait[s] = -1;
        end
      end
    end
  end

  // queues n beats and the requests and notify they should produce
  task automatic queue_stream(input int s, input int n, input logic [DATA_BYTES-1:0] last_keep);
    stream_beat_t b;
    wr_req_t r;
    notify_t nt;
    logic [BYTES_W-1:0] total;
    int left;
    int idx;
    total = '0;
    for (int i = 0; i < n; i++) begin
      b.data = {$urandom(), $urandom()};
      b.keep = (i == n - 1) ? last_keep : '1;
      b.last = (i == n - 1);
      total += BYTES_W'($countones(b.keep));
      drive_q[s].push_back(b);
      exp_beats[s].push_back(b);
    end
    left = n;
    idx = 0;
    // full transfers until the remainder closes the stream
    while (left > 0) begin
      r = '0;
      r.stream_id = STRM_ID_W'(s);
      r.vaddr = mem_config[s].base_addr + ADDR_W'(idx * TRANSFER_BYTES);
      r.beats = BEATS_W'((left > TRANSFER_BEATS) ? TRANSFER_BEATS : left);
      r.last = (left <= TRANSFER_BEATS);
      exp_req[s].push_back(r);
      left -= TRANSFER_BEATS;
      idx++;
    end
    nt = '0;
    nt.stream_id = STRM_ID_W'(s);
    nt.bytes = total;
    exp_ntf[s].push_back(nt);
  endtask

  function automatic bit traffic_idle();
    for (int s = 0; s < N_STRM; s++) begin
      if (drive_q[s].size() != 0 || exp_beats[s].size() != 0 || exp_req[s].size() != 0 ||
          exp_ntf[s].size() != 0 || pend[s].size() != 0 || cq_wait[s] >= 0) begin
        return 1'b0;
      end
    end
    return !cq_wr_valid;
  endfunction

  task automatic wait_drain(input string what);
    int cycles = 0;
    if (aborted) begin
      return;
    end
    while (!traffic_idle() && cycles < 3000) begin
      @(posedge clk);
      cycles++;
    end
    if (!traffic_idle()) begin
      errors++;
      aborted = 1'b1;
      $display("ERROR %0t: timeout, %s traffic did not finish in %0d cycles", $time, what, cycles);
    end
  endtask

  // reset moves only on the falling edge and spans 16 rising edges
  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic test_single_stream();
    // 9 full beats plus 5 bytes make 77
    queue_stream(0, 10, 8'h1f);
    wait_drain("single stream");
  endtask

  task automatic test_short_stream();
    queue_stream(1, 1, 8'h01);
    wait_drain("short stream");
  endtask

  task automatic test_dual_streams();
    queue_stream(0, 10, 8'h1f);
    queue_stream(1, 7, 8'h07);
    wait_drain("dual stream");
  endtask

  task automatic test_back_pressure();
    bp_on = 1'b1;
    queue_stream(0, 10, 8'h1f);
    wait_drain("back-pressured single stream");
    queue_stream(0, 10, 8'h1f);
    queue_stream(1, 7, 8'h07);
    wait_drain("back-pressured dual stream");
    bp_on = 1'b0;
  endtask

  task automatic test_reset_restart();
    apply_reset();
    // second stream queued behind the first starts again at base_addr
    queue_stream(0, 6, 8'h3f);
    queue_stream(0, 3, 8'h03);
    wait_drain("back-to-back streams");
  endtask

  initial begin
    void'($urandom(92));
    clk = 1'b0;
    rst = 1'b1;
    sq_wr_ready = 1'b1;
    notify_ready = 1'b1;
    cq_wr = '0;
    cq_wr_valid = 1'b0;
    cq_fired = 1'b0;
    bp_on = 1'b0;
    aborted = 1'b0;
    errors = 0;
    checks = 0;
    for (int s = 0; s < N_STRM; s++) begin
      data_in[s] = '0;
      data_in_valid[s] = 1'b0;
      data_out_ready[s] = 1'b1;
      in_fired[s] = 1'b0;
      beats_seen[s] = 0;
      beats_done[s] = 0;
      cq_wait[s] = -1;
    end
    // distinct host buffers per stream
    mem_config[0].base_addr = 32'h1000_0000;
    mem_config[1].base_addr = 32'h2000_4000;
    apply_reset();
    test_single_stream();
    test_short_stream();
    test_dual_streams();
    test_back_pressure();
    test_reset_restart();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/output_writer_chk.sv
`default_nettype none

module output_writer_chk
  import owr_pkg::*;
(
  input wire logic         clk,
  input wire logic         rst,
  input wire stream_beat_t data_in [N_STRM],
  input wire logic         data_in_valid [N_STRM],
  input wire stream_beat_t data_out [N_STRM],
  input wire logic         data_out_valid [N_STRM],
  input wire logic         data_out_ready [N_STRM],
  input wire meta_word_u   sq_wr,
  input wire logic         sq_wr_valid,
  input wire logic         sq_wr_ready,
  input wire meta_word_u   notify,
  input wire logic         notify_valid,
  input wire logic         notify_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  for (genvar i = 0; i < N_STRM; i++) begin : g_strm
    // normalized input, only the final beat may be partial
    a_keep_full: assert property (@(posedge clk) disable iff (rst)
      data_in_valid[i] && !data_in[i].last |-> data_in[i].keep == '1)
      else $error("data_in[%0d] keep not full on a beat before last", i);

    // last beat keep packed from bit 0, at least one byte
    a_keep_contig: assert property (@(posedge clk) disable iff (rst)
      data_in_valid[i] && data_in[i].last |->
        (data_in[i].keep != '0) &&
        (((data_in[i].keep + 8'd1) & data_in[i].keep) == 8'd0))
      else $error("data_in[%0d] last keep not contiguous from bit 0", i);

    // stalled beat holds
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
      data_out_valid[i] && !data_out_ready[i] |=>
        data_out_valid[i] && $stable(data_out[i]))
      else $error("data_out[%0d] changed while stalled", i);
  end

  a_sq_stable: assert property (@(posedge clk) disable iff (rst)
    sq_wr_valid && !sq_wr_ready |=> sq_wr_valid && $stable(sq_wr))
    else $error("sq_wr changed while stalled");

  a_ntf_stable: assert property (@(posedge clk) disable iff (rst)
    notify_valid && !notify_ready |=> notify_valid && $stable(notify))
    else $error("notify changed while stalled");

endmodule

bind output_writer output_writer_chk u_chk (.*);

`default_nettype wire

//--- src/output_writer.sv
`default_nettype none

module output_writer
  import owr_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  stream_beat_t data_in [N_STRM],
  input  logic         data_in_valid [N_STRM],
  output logic         data_in_ready [N_STRM],
  input  mem_config_t  mem_config [N_STRM],
  output stream_beat_t data_out [N_STRM],
  output logic         data_out_valid [N_STRM],
  input  logic         data_out_ready [N_STRM],
  output meta_word_u   sq_wr,
  output logic         sq_wr_valid,
  input  logic         sq_wr_ready,
  input  cq_t          cq_wr,
  input  logic         cq_wr_valid,
  output logic         cq_wr_ready,
  output meta_word_u   notify,
  output logic         notify_valid,
  input  logic         notify_ready
);

  // fifo to writer
  stream_beat_t fifo_beat [N_STRM];
  logic fifo_valid [N_STRM];
  logic fifo_ready [N_STRM];
  logic [LEVEL_W-1:0] fifo_level [N_STRM];
  logic fifo_last [N_STRM];
  // writer requests toward the sq arbiter
  meta_word_u req_word [N_STRM];
  logic req_valid [N_STRM];
  logic req_ready [N_STRM];
  // writer notifies toward the notify arbiter
  meta_word_u ntf_word [N_STRM];
  logic ntf_valid [N_STRM];
  logic ntf_ready [N_STRM];
  // routed completions
  logic cq_valid [N_STRM];
  logic cq_ready [N_STRM];

  for (genvar i = 0; i < N_STRM; i++) begin : g_strm
    beat_fifo u_fifo (
      .clk          (clk),
      .rst          (rst),
      .wr_beat      (data_in[i]),
      .wr_valid     (data_in_valid[i]),
      .wr_ready     (data_in_ready[i]),
      .rd_beat      (fifo_beat[i]),
      .rd_valid     (fifo_valid[i]),
      .rd_ready     (fifo_ready[i]),
      .level        (fifo_level[i]),
      .last_buffered(fifo_last[i])
    );

    // stream id from the loop index
    stream_writer u_writer (
      .clk           (clk),
      .rst           (rst),
      .strm_id       (STRM_ID_W'(i)),
      .mem_config    (mem_config[i]),
      .level         (fifo_level[i]),
      .last_buffered (fifo_last[i]),
      .beat_in       (fifo_beat[i]),
      .beat_in_valid (fifo_valid[i]),
      .beat_in_ready (fifo_ready[i]),
      .beat_out      (data_out[i]),
      .beat_out_valid(data_out_valid[i]),
      .beat_out_ready(data_out_ready[i]),
      .req           (req_word[i]),
      .req_valid     (req_valid[i]),
      .req_ready     (req_ready[i]),
      .cq_valid      (cq_valid[i]),
      .cq_ready      (cq_ready[i]),
      .ntf           (ntf_word[i]),
      .ntf_valid     (ntf_valid[i]),
      .ntf_ready     (ntf_ready[i])
    );
  end

  // submission queue
  meta_arbiter u_sq_arb (
    .clk      (clk),
    .rst      (rst),
    .in_word  (req_word),
    .in_valid (req_valid),
    .in_ready (req_ready),
    .out_word (sq_wr),
    .out_valid(sq_wr_valid),
    .out_ready(sq_wr_ready)
  );

  // notifications
  meta_arbiter u_ntf_arb (
    .clk      (clk),
    .rst      (rst),
    .in_word  (ntf_word),
    .in_valid (ntf_valid),
    .in_ready (ntf_ready),
    .out_word (notify),
    .out_valid(notify_valid),
    .out_ready(notify_ready)
  );

  // completions back by stream id
  cq_router u_cq_router (
    .clk         (clk),
    .rst         (rst),
    .cq_in       (cq_wr),
    .cq_in_valid (cq_wr_valid),
    .cq_in_ready (cq_wr_ready),
    .cq_out_valid(cq_valid),
    .cq_out_ready(cq_ready)
  );

endmodule

`default_nettype wire

//--- src/cq_router.sv
`default_nettype none

module cq_router
  import owr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  cq_t  cq_in,
  input  logic cq_in_valid,
  output logic cq_in_ready,
  output logic cq_out_valid [N_STRM],
  input  logic cq_out_ready [N_STRM]
);

  logic cq_fire;

  // host stalls only when the addressed slot still holds a completion
  assign cq_in_ready = !cq_out_valid[cq_in.stream_id];
  assign cq_fire = cq_in_valid && cq_in_ready;

  // one slot per stream, the slot flag is the valid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N_STRM; i++) begin
        cq_out_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < N_STRM; i++) begin
        if (cq_fire && (cq_in.stream_id == STRM_ID_W'(i))) begin
          cq_out_valid[i] <= 1'b1;
        end else if (cq_out_ready[i]) begin
          // writer took it
          cq_out_valid[i] <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/meta_arbiter.sv
`default_nettype none

module meta_arbiter
  import owr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  meta_word_u in_word [N_STRM],
  input  logic       in_valid [N_STRM],
  output logic       in_ready [N_STRM],
  output meta_word_u out_word,
  output logic       out_valid,
  input  logic       out_ready
);

  // highest priority stream
  logic [STRM_ID_W-1:0] rr_ptr;
  logic [STRM_ID_W-1:0] grant_idx;
  logic grant_any;
  logic accept;

  // output register empty or draining this cycle
  assign accept = !out_valid || out_ready;

  // first requester at or after the pointer
  always_comb begin
    logic [STRM_ID_W-1:0] idx;
    grant_any = 1'b0;
    grant_idx = rr_ptr;
    // walk downward so the nearest offset wins
    for (int i = N_STRM - 1; i >= 0; i--) begin
      idx = rr_ptr + STRM_ID_W'(i);
      if (in_valid[idx]) begin
        grant_any = 1'b1;
        grant_idx = idx;
      end
    end
  end

  // only the granted input sees ready
  always_comb begin
    for (int i = 0; i < N_STRM; i++) begin
      in_ready[i] = accept && grant_any && (grant_idx == STRM_ID_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rr_ptr <= '0;
    end else if (accept) begin
      out_valid <= grant_any;
      // pointer moves past the winner
      if (grant_any) begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // word register
  always_ff @(posedge clk) begin
    if (accept && grant_any) begin
      out_word <= in_word[grant_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/stream_writer.sv
`default_nettype none

module stream_writer
  import owr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [STRM_ID_W-1:0] strm_id,
  input  mem_config_t          mem_config,
  input  logic [LEVEL_W-1:0]   level,
  input  logic                 last_buffered,
  input  stream_beat_t         beat_in,
  input  logic                 beat_in_valid,
  output logic                 beat_in_ready,
  output stream_beat_t         beat_out,
  output logic                 beat_out_valid,
  input  logic                 beat_out_ready,
  output meta_word_u           req,
  output logic                 req_valid,
  input  logic                 req_ready,
  input  logic                 cq_valid,
  output logic                 cq_ready,
  output meta_word_u           ntf,
  output logic                 ntf_valid,
  input  logic                 ntf_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_SEND,
    S_WAIT_CQ,
    S_NOTIFY
  } state_t;

  state_t state;
  // size and end flag of the transfer in flight
  logic [BEATS_W-1:0] xfer_beats;
  logic xfer_last;
  logic [BEATS_W-1:0] beats_left;
  // transfer index within the stream
  logic [ADDR_W-1:0] xfer_idx;
  // running byte total of the stream
  logic [BYTES_W-1:0] byte_total;
  logic full_xfer;
  logic start;
  logic [BEATS_W-1:0] next_beats;
  logic beat_fire;

  // number of valid bytes in a keep mask
  function automatic logic [KEEP_CNT_W-1:0] keep_bytes(input logic [DATA_BYTES-1:0] keep);
    logic [KEEP_CNT_W-1:0] n;
    n = '0;
    for (int i = 0; i < DATA_BYTES; i++) begin
      n = n + KEEP_CNT_W'(keep[i]);
    end
    return n;
  endfunction

  // enough beats for a full transfer
  assign full_xfer = (level >= LEVEL_W'(TRANSFER_BEATS));
  // start on a full transfer or on any buffered stream end
  assign start = (state == S_IDLE) && (full_xfer || last_buffered);
  // the last beat is the newest buffered entry so level stops at it
  assign next_beats = full_xfer ? BEATS_W'(TRANSFER_BEATS) : BEATS_W'(level);

  // request word
  always_comb begin
    req = '0;
    req.req.stream_id = strm_id;
    req.req.vaddr = mem_config.base_addr + xfer_idx * ADDR_W'(TRANSFER_BYTES);
    req.req.beats = xfer_beats;
    req.req.last = xfer_last;
  end

  // notify word, stable through S_NOTIFY
  always_comb begin
    ntf = '0;
    ntf.ntf.stream_id = strm_id;
    ntf.ntf.bytes = byte_total;
  end

  assign req_valid = (state == S_REQ);
  assign cq_ready = (state == S_WAIT_CQ);
  assign ntf_valid = (state == S_NOTIFY);

  // beats pass from the fifo head during S_SEND only
  assign beat_out = beat_in;
  assign beat_out_valid = (state == S_SEND) && beat_in_valid;
  assign beat_in_ready = (state == S_SEND) && beat_out_ready;
  assign beat_fire = beat_out_valid && beat_out_ready;

  // transfer shape latched at start
  always_ff @(posedge clk) begin
    if (start) begin
      xfer_beats <= next_beats;
      // ends the stream only if the last beat fits in this transfer
      xfer_last <= last_buffered && (level <= LEVEL_W'(TRANSFER_BEATS));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      beats_left <= '0;
      xfer_idx <= '0;
      byte_total <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_REQ;
          end
        end
        S_REQ: begin
          if (req_ready) begin
            beats_left <= xfer_beats;
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (beat_fire) begin
            beats_left <= beats_left - 1'b1;
            byte_total <= byte_total + BYTES_W'(keep_bytes(beat_in.keep));
            if (beats_left == BEATS_W'(1)) begin
              state <= S_WAIT_CQ;
            end
          end
        end
        S_WAIT_CQ: begin
          // one completion per transfer
          if (cq_valid) begin
            if (xfer_last) begin
              xfer_idx <= '0;
              state <= S_NOTIFY;
            end else begin
              xfer_idx <= xfer_idx + 1'b1;
              state <= S_IDLE;
            end
          end
        end
        S_NOTIFY: begin
          if (ntf_ready) begin
            byte_total <= '0;
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/beat_fifo.sv
`default_nettype none

module beat_fifo
  import owr_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  stream_beat_t       wr_beat,
  input  logic               wr_valid,
  output logic               wr_ready,
  output stream_beat_t       rd_beat,
  output logic               rd_valid,
  input  logic               rd_ready,
  output logic [LEVEL_W-1:0] level,
  output logic               last_buffered
);

  stream_beat_t mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [LEVEL_W-1:0] count;
  // number of stream ends currently held
  logic [LEVEL_W-1:0] last_cnt;
  logic push;
  logic pop;

  // input held off while a stream end is buffered so the last beat is always the newest entry
  assign wr_ready = (count != LEVEL_W'(FIFO_DEPTH)) && (last_cnt == '0);
  assign rd_valid = (count != '0);
  assign push = wr_valid && wr_ready;
  assign pop = rd_valid && rd_ready;

  // head of queue straight from the array
  assign rd_beat = mem[rd_ptr];
  assign level = count;
  assign last_buffered = (last_cnt != '0);

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      last_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // last beat count follows the beats in and out
      if ((push && wr_beat.last) && !(pop && rd_beat.last)) begin
        last_cnt <= last_cnt + 1'b1;
      end else if ((pop && rd_beat.last) && !(push && wr_beat.last)) begin
        last_cnt <= last_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/owr_pkg.sv
`default_nettype none

package owr_pkg;

  // stream count, kept a power of two
  localparam int N_STRM = 2;
  localparam int STRM_ID_W = $clog2(N_STRM);

  // beat geometry
  localparam int DATA_BYTES = 8;
  localparam int DATA_W = DATA_BYTES * 8;
  localparam int KEEP_CNT_W = $clog2(DATA_BYTES + 1);

  // one transfer is at most four beats
  localparam int TRANSFER_BEATS = 4;
  localparam int TRANSFER_BYTES = TRANSFER_BEATS * DATA_BYTES;
  localparam int BEATS_W = $clog2(TRANSFER_BEATS + 1);

  // per-stream beat buffer
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

  // host side widths
  localparam int ADDR_W = 32;
  localparam int BYTES_W = 32;
  localparam int CQ_W = 8;
  localparam int META_W = 40;

  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] keep;
    logic                  last;
  } stream_beat_t;

  // host buffer start of one stream
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
  } mem_config_t;

  typedef struct packed {
    logic [STRM_ID_W-1:0]      stream_id;
    logic [CQ_W-STRM_ID_W-1:0] spare;
  } cq_t;

  // stream_id leads both meta views so it sits at the same bits
  typedef struct packed {
    logic [STRM_ID_W-1:0]                          stream_id;
    logic [ADDR_W-1:0]                             vaddr;
    logic [BEATS_W-1:0]                            beats;
    logic                                          last;
    logic [META_W-STRM_ID_W-ADDR_W-BEATS_W-2:0]    pad;
  } wr_req_t;

  typedef struct packed {
    logic [STRM_ID_W-1:0]                 stream_id;
    logic [BYTES_W-1:0]                   bytes;
    logic [META_W-STRM_ID_W-BYTES_W-1:0]  pad;
  } notify_t;

  // carried opaque by the arbiters, decoded at the sq and notify sides
  typedef union packed {
    wr_req_t req;
    notify_t ntf;
  } meta_word_u;

endpackage

`default_nettype wire
